/* multicycleCtrl.f */
hw/cpuCtrlPkg.sv
hw/instrDecoder.sv
hw/ctrlSequencer.sv
hw/ctrlWordGen.sv
hw/multicycleCtrl.sv
tb/tbClock.sv
tb/multicycleCtrlTb.sv

/* Makefile */
LOG := sim.log

.PHONY: help test clean

help:
	@echo "make test   build the testbench with Verilator and run it"
	@echo "make clean  remove the build directory and the log"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/1ns -j 0 \
		--top-module multicycleCtrlTb -f multicycleCtrl.f -o simv
	./obj_dir/simv > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG); then echo "test: failure reported in $(LOG)"; exit 1; fi
	@grep -q "ALL CHECKS PASSED" $(LOG) || (echo "test: no result in $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

/* tb/multicycleCtrlTb.sv */
`timescale 1ns/1ns
`default_nettype none

module multicycleCtrlTb
    import cpuCtrlPkg::*;
();

    logic     clk;
    logic     reset;
    opcodeT   opcode;
    functT    funct;
    logic     overflow;
    logic     memReady;
    logic     memValid, memWrite, iorD, irWrite, pcWrite, pcWriteCond;
    logic     aluSrcA, aluOutWrite, regWrite, aWrite, bWrite, extendOp;
    logic     epcWrite, causeWrite;
    pcSourceT pcSource;
    branchOpT branchOp;
    aluSrcBT  aluSrcB;
    aluOpT    aluOp;
    regDstT   regDst;
    memToRegT memToReg;
    causeT    intCause;
    logic     anyWrite;

    logic [7:0] lfsr = 8'd48;
    int         testsRun = 0;
    int         testsFailed = 0;
    int         checks = 0;
    int         errors = 0;
    logic       timedOut = 1'b0;

    tbClock clockGen (.clk(clk));

    multicycleCtrl DUT (.*);

    assign anyWrite = regWrite | pcWrite | pcWriteCond | irWrite | memWrite | epcWrite
        | causeWrite | aluOutWrite | aWrite | bWrite;

    // taps for x^8 + x^6 + x^5 + x^4 + 1
    function automatic logic [7:0] lfsrStep(input logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
    endfunction

    function automatic int randomBits(input int n);
        int value;
        value = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsrStep(lfsr);
            value = (value << 1) | int'(lfsr[0]);
        end
        return value;
    endfunction

    // expected class from the instruction list
    function automatic instrClassT refClass(input opcodeT op, input functT fn);
        case (op)
            OpR:           return (fn inside {FunctAdd, FunctSub, FunctAnd, FunctSlt}) ?
                                  ClassAluR : ClassUndef;
            OpAddi, OpAddiu: return ClassAluI;
            OpBeq, OpBne:  return ClassBranch;
            OpLw:          return ClassLoad;
            OpSw:          return ClassStore;
            OpJ:           return ClassJump;
            default:       return ClassUndef;
        endcase
    endfunction

    function automatic aluOpT refAluOp(input opcodeT op, input functT fn);
        if (op != OpR) begin
            return AluAdd;
        end
        case (fn)
            FunctSub: return AluSub;
            FunctAnd: return AluAnd;
            FunctSlt: return AluSlt;
            default:  return AluAdd;
        endcase
    endfunction

    task automatic checkThat(input logic ok, input string msg);
        checks++;
        assert (ok) else begin
            errors++;
            $display("MISMATCH at %0t ns: %s", $time, msg);
        end
    endtask

    task automatic reportTest(input string name, input int errorsBefore);
        testsRun++;
        if (errors == errorsBefore && !timedOut) begin
            $display("test %s: ok", name);
        end else begin
            testsFailed++;
            $display("test %s: %0d errors", name, errors - errorsBefore);
        end
    endtask

    task automatic checkResetWord(input string when);
        checkThat(!anyWrite, $sformatf("write enable active %s", when));
        checkThat(memValid && !memWrite && !iorD, $sformatf("bad memory request %s", when));
    endtask

    task automatic applyReset();
        int errorsBefore;
        errorsBefore = errors;
        reset = 1'b1;
        @(posedge clk);
        #1;
        @(negedge clk);
        checkResetWord("during reset");
        @(posedge clk);
        #1;
        reset = 1'b0;
        checkResetWord("in the first cycle after reset");
        reportTest("reset", errorsBefore);
    endtask

    // entered 1 ns after the edge that starts the first Fetch cycle
    task automatic runInstr(input string name, input opcodeT op, input functT fn,
                            input logic ovf);
        instrClassT cls;
        logic       trap, sawLatch, done, prevWaiting, prevMemWrite, prevIorD, memWriteSeen;
        int         cycles, waits, base, regWrites, excCount, condWrites, jumpWrites;
        int         expRegWrites, errorsBefore;
        if (timedOut) begin
            return;
        end
        cls = refClass(op, fn);
        trap = ovf && (op == OpAddi || (cls == ClassAluR && fn inside {FunctAdd, FunctSub}));
        case (cls)
            ClassLoad:                          base = 7;
            ClassBranch, ClassJump, ClassUndef: base = 5;
            default:                            base = 6;
        endcase
        expRegWrites = (((cls == ClassAluR || cls == ClassAluI) && !trap) ||
                        cls == ClassLoad) ? 1 : 0;
        {sawLatch, done, prevWaiting, prevMemWrite, prevIorD, memWriteSeen} = '0;
        {cycles, waits, regWrites, excCount, condWrites, jumpWrites} = '0;
        errorsBefore = errors;

        while (!done && !timedOut) begin
            @(negedge clk);
            cycles++;
            // a pending request must hold still until accepted
            if (prevWaiting) begin
                checkThat(memValid && memWrite == prevMemWrite && iorD == prevIorD,
                          $sformatf("%s: memory request changed while waiting", name));
            end
            if (memValid && !memReady) begin
                waits++;
            end
            prevWaiting  = memValid && !memReady;
            prevMemWrite = memWrite;
            prevIorD     = iorD;
            memWriteSeen = memWriteSeen | memWrite;
            sawLatch     = sawLatch | irWrite;
            // PC plus four written back while the IR loads
            if (irWrite) begin
                checkThat(pcWrite && pcSource == PcAluResult && !aluSrcA &&
                          aluSrcB == SrcBFour && aluOp == AluAdd,
                          $sformatf("%s: PC increment word wrong", name));
            end
            if (aluSrcA && aluOutWrite &&
                cls inside {ClassAluR, ClassAluI, ClassLoad, ClassStore}) begin
                checkThat(aluOp == refAluOp(op, fn), $sformatf("%s: exec aluOp %0d", name, aluOp));
                if (cls == ClassAluR) begin
                    checkThat(aluSrcB == SrcBReg,
                              $sformatf("%s: exec aluSrcB %0d", name, aluSrcB));
                end else begin
                    // sign-extended immediate as second operand
                    checkThat(aluSrcB == SrcBImm && extendOp,
                              $sformatf("%s: immediate operand select wrong", name));
                end
            end
            if (regWrite) begin
                regWrites++;
                if (cls == ClassAluR) begin
                    checkThat(regDst == RegDstRd &&
                              memToReg == ((fn == FunctSlt) ? MemToRegSlt : MemToRegAlu),
                              $sformatf("%s: regDst/memToReg wrong", name));
                end else if (cls == ClassAluI) begin
                    checkThat(regDst == RegDstRt && memToReg == MemToRegAlu,
                              $sformatf("%s: regDst/memToReg wrong", name));
                end else begin
                    checkThat(memToReg == MemToRegMem, $sformatf("%s: memToReg wrong", name));
                end
            end
            if (pcWriteCond) begin
                condWrites++;
                checkThat(pcSource == PcBranch &&
                          branchOp == ((op == OpBne) ? BranchNe : BranchEq),
                          $sformatf("%s: branch pcSource/branchOp wrong", name));
            end
            if (pcWrite && !irWrite && !epcWrite) begin
                jumpWrites++;
                checkThat(pcSource == PcJump, $sformatf("%s: jump pcSource wrong", name));
            end
            if (epcWrite) begin
                excCount++;
                checkThat(causeWrite && pcWrite && pcSource == PcException &&
                          intCause == (trap ? CauseOverflow : CauseUndef),
                          $sformatf("%s: exception word wrong", name));
            end
            // the retire cycle is the only idle word after the IR load
            if (sawLatch && !memValid && !anyWrite) begin
                done = 1'b1;
            end else if (cycles > 50) begin
                timedOut = 1'b1;
                $display("timeout: %s did not retire within 50 cycles", name);
            end
            @(posedge clk);
            #1;
            overflow = ovf && aluSrcA && aluOutWrite;
            if (irWrite) begin
                opcode = op;
                funct  = fn;
            end
        end

        if (!timedOut) begin
            checkThat(memValid && !iorD && !memWrite, $sformatf("%s: no Fetch after retire", name));
            checkThat(cycles == base + waits,
                      $sformatf("%s: length %0d, expected %0d", name, cycles, base + waits));
            checkThat(regWrites == expRegWrites, $sformatf("%s: %0d regWrite", name, regWrites));
            checkThat(excCount == ((trap || cls == ClassUndef) ? 1 : 0),
                      $sformatf("%s: %0d exceptions", name, excCount));
            checkThat(condWrites == ((cls == ClassBranch) ? 1 : 0),
                      $sformatf("%s: %0d pcWriteCond", name, condWrites));
            checkThat(jumpWrites == ((cls == ClassJump) ? 1 : 0),
                      $sformatf("%s: %0d jump pcWrite", name, jumpWrites));
            checkThat(memWriteSeen == (cls == ClassStore), $sformatf("%s: memWrite wrong", name));
        end
        reportTest(name, errorsBefore);
    endtask

    // memory answers each request after 0 to 3 wait cycles
    initial begin
        int   delayLeft;
        logic pending;
        memReady  = 1'b0;
        pending   = 1'b0;
        delayLeft = 0;
        forever begin
            @(posedge clk);
            #1;
            if (memValid !== 1'b1) begin
                memReady = 1'b0;
                pending  = 1'b0;
            end else begin
                if (!pending) begin
                    delayLeft = randomBits(2);
                    pending   = 1'b1;
                end
                if (delayLeft == 0) begin
                    memReady = 1'b1;
                    pending  = 1'b0;
                end else begin
                    memReady = 1'b0;
                    delayLeft--;
                end
            end
        end
    end

    initial begin
        reset    = 1'b1;
        opcode   = OpR;
        funct    = FunctAdd;
        overflow = 1'b0;
        applyReset();

        runInstr("add", OpR, FunctAdd, 1'b0);
        runInstr("sub", OpR, FunctSub, 1'b0);
        runInstr("and", OpR, FunctAnd, 1'b0);
        runInstr("slt", OpR, FunctSlt, 1'b0);
        runInstr("addi", OpAddi, 6'h00, 1'b0);
        runInstr("addiu", OpAddiu, 6'h00, 1'b0);
        runInstr("add with overflow", OpR, FunctAdd, 1'b1);
        runInstr("sub with overflow", OpR, FunctSub, 1'b1);
        runInstr("addi with overflow", OpAddi, 6'h00, 1'b1);
        runInstr("addiu with overflow", OpAddiu, 6'h00, 1'b1);
        runInstr("beq", OpBeq, 6'h00, 1'b0);
        runInstr("bne", OpBne, 6'h00, 1'b0);
        runInstr("j", OpJ, 6'h00, 1'b0);
        runInstr("undefined opcode", 6'h3f, 6'h00, 1'b0);
        runInstr("undefined funct", OpR, 6'h00, 1'b0);
        // extra loads and stores for more back-pressure patterns
        repeat (4) begin
            runInstr("lw", OpLw, 6'h00, 1'b0);
            runInstr("sw", OpSw, 6'h00, 1'b0);
        end

        $display("tests run %0d, failed %0d, checks %0d, errors %0d",
                 testsRun, testsFailed, checks, errors);
        if (errors == 0 && testsFailed == 0 && !timedOut) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb/tbClock.sv */
`timescale 1ns/1ns
`default_nettype none

// free-running clock, 4 ns period
module tbClock (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #2;
            clk = ~clk;
        end
    end

endmodule

`default_nettype wire

/* hw/multicycleCtrl.sv */
`timescale 1ns/1ns
`default_nettype none

module multicycleCtrl
    import cpuCtrlPkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  opcodeT   opcode,
    input  functT    funct,
    input  logic     overflow,
    input  logic     memReady,
    output logic     memValid,
    output logic     memWrite,
    output logic     iorD,
    output logic     irWrite,
    output logic     pcWrite,
    output logic     pcWriteCond,
    output pcSourceT pcSource,
    output branchOpT branchOp,
    output logic     aluSrcA,
    output aluSrcBT  aluSrcB,
    output aluOpT    aluOp,
    output logic     aluOutWrite,
    output logic     regWrite,
    output regDstT   regDst,
    output memToRegT memToReg,
    output logic     aWrite,
    output logic     bWrite,
    output logic     extendOp,
    output logic     epcWrite,
    output logic     causeWrite,
    output causeT    intCause
);

    instrClassT instrClass;
    aluOpT      decAluOp;
    logic       overflowTrap;
    ctrlStateT  state;
    causeT      cause;

    instrDecoder u_decoder (
        .opcode       (opcode),
        .funct        (funct),
        .instrClass   (instrClass),
        .aluOp        (decAluOp),
        .overflowTrap (overflowTrap)
    );

    ctrlSequencer u_sequencer (
        .clk          (clk),
        .reset        (reset),
        .instrClass   (instrClass),
        .overflowTrap (overflowTrap),
        .overflow     (overflow),
        .memReady     (memReady),
        .state        (state),
        .cause        (cause)
    );

    ctrlWordGen u_wordGen (
        .state       (state),
        .aluOp       (decAluOp),
        .instrClass  (instrClass),
        .opcode      (opcode),
        .cause       (cause),
        .memValid    (memValid),
        .memWrite    (memWrite),
        .iorD        (iorD),
        .irWrite     (irWrite),
        .pcWrite     (pcWrite),
        .pcWriteCond (pcWriteCond),
        .pcSource    (pcSource),
        .branchOp    (branchOp),
        .aluSrcA     (aluSrcA),
        .aluSrcB     (aluSrcB),
        .aluOpOut    (aluOp),
        .aluOutWrite (aluOutWrite),
        .regWrite    (regWrite),
        .regDst      (regDst),
        .memToReg    (memToReg),
        .aWrite      (aWrite),
        .bWrite      (bWrite),
        .extendOp    (extendOp),
        .epcWrite    (epcWrite),
        .causeWrite  (causeWrite),
        .intCause    (intCause)
    );

endmodule

`default_nettype wire

/* hw/ctrlWordGen.sv */
`timescale 1ns/1ns
`default_nettype none

module ctrlWordGen
    import cpuCtrlPkg::*;
(
    input  ctrlStateT  state,
    input  aluOpT      aluOp,
    input  instrClassT instrClass,
    input  opcodeT     opcode,
    input  causeT      cause,
    output logic       memValid,
    output logic       memWrite,
    output logic       iorD,
    output logic       irWrite,
    output logic       pcWrite,
    output logic       pcWriteCond,
    output pcSourceT   pcSource,
    output branchOpT   branchOp,
    output logic       aluSrcA,
    output aluSrcBT    aluSrcB,
    output aluOpT      aluOpOut,
    output logic       aluOutWrite,
    output logic       regWrite,
    output regDstT     regDst,
    output memToRegT   memToReg,
    output logic       aWrite,
    output logic       bWrite,
    output logic       extendOp,
    output logic       epcWrite,
    output logic       causeWrite,
    output causeT      intCause
);

    always_comb begin
        // idle word, same as the retire cycle
        memValid    = 1'b0;
        memWrite    = 1'b0;
        iorD        = 1'b0;
        irWrite     = 1'b0;
        pcWrite     = 1'b0;
        pcWriteCond = 1'b0;
        pcSource    = PcAluResult;
        branchOp    = BranchEq;
        aluSrcA     = 1'b0;
        aluSrcB     = SrcBReg;
        aluOpOut    = AluPass;
        aluOutWrite = 1'b0;
        regWrite    = 1'b0;
        regDst      = RegDstRt;
        memToReg    = MemToRegMem;
        aWrite      = 1'b0;
        bWrite      = 1'b0;
        extendOp    = 1'b0;
        epcWrite    = 1'b0;
        causeWrite  = 1'b0;
        intCause    = CauseUndef;

        case (state)
            Fetch: begin
                memValid = 1'b1;
            end
            // latch IR and step PC by four
            FetchLatch: begin
                irWrite  = 1'b1;
                pcWrite  = 1'b1;
                aluSrcB  = SrcBFour;
                aluOpOut = AluAdd;
            end
            // branch target goes to ALUOut here
            Decode: begin
                aWrite      = 1'b1;
                bWrite      = 1'b1;
                aluOutWrite = 1'b1;
                aluSrcB     = SrcBBranchOffset;
                aluOpOut    = AluAdd;
                extendOp    = 1'b1;
            end
            ExecR, ExecI, AddrCalc: begin
                aluSrcA     = 1'b1;
                aluSrcB     = (instrClass == ClassAluR) ? SrcBReg : SrcBImm;
                aluOpOut    = aluOp;
                aluOutWrite = 1'b1;
                extendOp    = (instrClass != ClassAluR);
            end
            WriteR: begin
                regWrite = 1'b1;
                regDst   = RegDstRd;
                memToReg = (aluOp == AluSlt) ? MemToRegSlt : MemToRegAlu;
            end
            WriteI: begin
                regWrite = 1'b1;
                memToReg = MemToRegAlu;
            end
            Branch: begin
                aluSrcA     = 1'b1;
                aluOpOut    = aluOp;
                pcWriteCond = 1'b1;
                pcSource    = PcBranch;
                branchOp    = (opcode == OpBne) ? BranchNe : BranchEq;
            end
            MemRead: begin
                memValid = 1'b1;
                iorD     = 1'b1;
            end
            MemWrite: begin
                memValid = 1'b1;
                memWrite = 1'b1;
                iorD     = 1'b1;
            end
            WriteMem: begin
                regWrite = 1'b1;
            end
            Jump: begin
                pcWrite  = 1'b1;
                pcSource = PcJump;
            end
            // EPC takes PC minus four, the faulting instruction
            Except: begin
                aluSrcB    = SrcBFour;
                aluOpOut   = AluSub;
                epcWrite   = 1'b1;
                causeWrite = 1'b1;
                intCause   = cause;
                pcWrite    = 1'b1;
                pcSource   = PcException;
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

/* hw/ctrlSequencer.sv */
`timescale 1ns/1ns
`default_nettype none

module ctrlSequencer
    import cpuCtrlPkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  instrClassT instrClass,
    input  logic       overflowTrap,
    input  logic       overflow,
    input  logic       memReady,
    output ctrlStateT  state,
    output causeT      cause
);

    ctrlStateT nextState;
    logic      trapTaken;

    // overflow only matters for the signed adds and sub
    assign trapTaken = overflow && overflowTrap;

    always_comb begin
        nextState = state;
        case (state)
            // wait for the instruction word
            Fetch: begin
                if (memReady) begin
                    nextState = FetchLatch;
                end
            end
            FetchLatch: begin
                nextState = Decode;
            end
            Decode: begin
                case (instrClass)
                    ClassAluR:   nextState = ExecR;
                    ClassAluI:   nextState = ExecI;
                    ClassBranch: nextState = Branch;
                    ClassLoad:   nextState = AddrCalc;
                    ClassStore:  nextState = AddrCalc;
                    ClassJump:   nextState = Jump;
                    default:     nextState = Except;
                endcase
            end
            ExecR: begin
                nextState = trapTaken ? Except : WriteR;
            end
            ExecI: begin
                nextState = trapTaken ? Except : WriteI;
            end
            AddrCalc: begin
                if (instrClass == ClassStore) begin
                    nextState = MemWrite;
                end else begin
                    nextState = MemRead;
                end
            end
            MemRead: begin
                if (memReady) begin
                    nextState = WriteMem;
                end
            end
            MemWrite: begin
                if (memReady) begin
                    nextState = Retire;
                end
            end
            WriteR, WriteI, WriteMem, Branch, Jump, Except: begin
                nextState = Retire;
            end
            // retire cycle with all lines idle
            default: begin
                nextState = Fetch;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= Fetch;
        end else begin
            state <= nextState;
        end
    end

    // cause latched on the way into Except
    always_ff @(posedge clk) begin
        if (nextState == Except) begin
            cause <= (state == Decode) ? CauseUndef : CauseOverflow;
        end
    end

endmodule

`default_nettype wire

/* hw/instrDecoder.sv */
`timescale 1ns/1ns
`default_nettype none

module instrDecoder
    import cpuCtrlPkg::*;
(
    input  opcodeT     opcode,
    input  functT      funct,
    output instrClassT instrClass,
    output aluOpT      aluOp,
    output logic       overflowTrap
);

    always_comb begin
        // anything not listed below is undefined
        instrClass   = ClassUndef;
        aluOp        = AluPass;
        overflowTrap = 1'b0;

        case (opcode)
            OpR: begin
                instrClass = ClassAluR;
                case (funct)
                    FunctAdd: begin
                        aluOp        = AluAdd;
                        overflowTrap = 1'b1;
                    end
                    FunctSub: begin
                        aluOp        = AluSub;
                        overflowTrap = 1'b1;
                    end
                    FunctAnd: aluOp = AluAnd;
                    FunctSlt: aluOp = AluSlt;
                    default:  instrClass = ClassUndef;
                endcase
            end
            OpAddi: begin
                instrClass   = ClassAluI;
                aluOp        = AluAdd;
                overflowTrap = 1'b1;
            end
            // unsigned add never traps
            OpAddiu: begin
                instrClass = ClassAluI;
                aluOp      = AluAdd;
            end
            OpBeq, OpBne: begin
                // compare by subtraction, the datapath checks zero
                instrClass = ClassBranch;
                aluOp      = AluSub;
            end
            OpLw: begin
                instrClass = ClassLoad;
                aluOp      = AluAdd;
            end
            OpSw: begin
                instrClass = ClassStore;
                aluOp      = AluAdd;
            end
            OpJ: instrClass = ClassJump;
            default: instrClass = ClassUndef;
        endcase
    end

endmodule

`default_nettype wire

/* hw/cpuCtrlPkg.sv */
`default_nettype none

package cpuCtrlPkg;

    // instruction fields
    typedef logic [5:0] opcodeT;
    typedef logic [5:0] functT;

    localparam opcodeT OpR     = 6'h00;
    localparam opcodeT OpJ     = 6'h02;
    localparam opcodeT OpBeq   = 6'h04;
    localparam opcodeT OpBne   = 6'h05;
    localparam opcodeT OpAddi  = 6'h08;
    localparam opcodeT OpAddiu = 6'h09;
    localparam opcodeT OpLw    = 6'h23;
    localparam opcodeT OpSw    = 6'h2b;

    localparam functT FunctAdd = 6'h20;
    localparam functT FunctSub = 6'h22;
    localparam functT FunctAnd = 6'h24;
    localparam functT FunctSlt = 6'h2a;

    typedef enum logic [2:0] {
        ClassAluR, ClassAluI, ClassBranch, ClassLoad, ClassStore, ClassJump, ClassUndef
    } instrClassT;

    typedef enum logic [3:0] {
        Fetch, FetchLatch, Decode, ExecR, ExecI, WriteR, WriteI, Branch,
        AddrCalc, MemRead, WriteMem, MemWrite, Jump, Except, Retire
    } ctrlStateT;

    // datapath control fields
    typedef logic [2:0] aluOpT;
    typedef logic [2:0] pcSourceT;
    typedef logic [1:0] regDstT;
    typedef logic [3:0] memToRegT;
    typedef logic [1:0] aluSrcBT;
    typedef logic [1:0] branchOpT;
    typedef logic       causeT;

    localparam aluOpT AluPass = 3'd0;
    localparam aluOpT AluAdd  = 3'd1;
    localparam aluOpT AluSub  = 3'd2;
    localparam aluOpT AluAnd  = 3'd3;
    localparam aluOpT AluSlt  = 3'd7;

    localparam pcSourceT PcAluResult = 3'd0;
    localparam pcSourceT PcAluOut    = 3'd1;
    localparam pcSourceT PcJump      = 3'd2;
    localparam pcSourceT PcException = 3'd3;
    localparam pcSourceT PcBranch    = 3'd5;

    localparam regDstT RegDstRt = 2'd0;
    localparam regDstT RegDstRd = 2'd1;

    localparam memToRegT MemToRegMem = 4'd0;
    localparam memToRegT MemToRegSlt = 4'd4;
    localparam memToRegT MemToRegAlu = 4'd5;

    localparam aluSrcBT SrcBReg          = 2'd0;
    localparam aluSrcBT SrcBFour         = 2'd1;
    localparam aluSrcBT SrcBBranchOffset = 2'd2;
    localparam aluSrcBT SrcBImm          = 2'd3;

    localparam branchOpT BranchEq = 2'd0;
    localparam branchOpT BranchNe = 2'd1;

    localparam causeT CauseUndef    = 1'b0;
    localparam causeT CauseOverflow = 1'b1;

endpackage

`default_nettype wire
